// ==== Makefile ====
# Verilator build and run of the bridge testbench
VERILATOR ?= verilator
SIM_TOP   ?= mem_bridge_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LOG       ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hdl/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(SIM_TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run FAILED, see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "run incomplete, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/halfword_addr_gen.sv ====
/* memory address of the current halfword
   loaded at the start of an access and stepped once per finished halfword */
`include "mem_bridge_consts.svh"

module halfword_addr_gen (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic                      advance,
  input  logic [`MB_ADDR_W-1:0]     byte_addr,
  output logic [`MB_MEM_ADDR_W-1:0] hw_addr
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hw_addr <= '0;
    end else if (start) begin
      // drop the byte lane bit
      hw_addr <= byte_addr[`MB_ADDR_W-1:1];
    end else if (advance) begin
      // wraps past the top of memory
      hw_addr <= hw_addr + `MB_MEM_ADDR_W'(1);
    end
  end

endmodule

// ==== hdl/load_assembler.sv ====
/* builds the load result from the captured halfwords
   sign or zero extends byte and halfword loads, rdata is valid while ack is high */
`include "mem_bridge_consts.svh"

module load_assembler (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic                      capture,
  input  mem_bridge_pkg::mem_req_t  req_data,
  input  logic [`MB_MEM_DATA_W-1:0] sram_rdata,
  output logic [`MB_DATA_W-1:0]     rdata
);

  logic [3:0][7:0]            bytes_q;
  logic [3:0][7:0]            bytes_d;
  logic [2:0]                 cursor_q;
  logic [2:0]                 cursor_d;
  logic [2:0]                 size;
  logic                       lane_q;
  logic                       signed_q;
  mem_bridge_pkg::mem_width_e width_q;

  assign size = mem_bridge_pkg::width_bytes(width_q);

  // ######################################
  // byte gathering

  // low lane only when the access starts on it
  always_comb begin
    bytes_d  = bytes_q;
    cursor_d = cursor_q;
    if (!lane_q && (cursor_d < size)) begin
      bytes_d[cursor_d[1:0]] = sram_rdata[7:0];
      cursor_d               = cursor_d + 3'd1;
    end
    if (cursor_d < size) begin
      bytes_d[cursor_d[1:0]] = sram_rdata[15:8];
      cursor_d               = cursor_d + 3'd1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cursor_q <= 3'd0;
      lane_q   <= 1'b0;
      signed_q <= 1'b0;
      width_q  <= mem_bridge_pkg::W_BYTE;
    end else if (start) begin
      cursor_q <= 3'd0;
      lane_q   <= req_data.addr[0];
      signed_q <= req_data.is_signed;
      width_q  <= req_data.width;
    end else if (capture) begin
      cursor_q <= cursor_d;
      // later halfwords start at lane 0
      lane_q   <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      bytes_q <= bytes_d;
    end
  end

  // ######################################
  // extension

  always_comb begin
    case (width_q)
      mem_bridge_pkg::W_BYTE:
        rdata = {{24{signed_q & bytes_q[0][7]}}, bytes_q[0]};
      mem_bridge_pkg::W_HALF:
        rdata = {{16{signed_q & bytes_q[1][7]}}, bytes_q[1], bytes_q[0]};
      default:
        rdata = bytes_q;
    endcase
  end

endmodule

// ==== hdl/mem_access_ctrl.sv ====
/* control FSM of the bridge: four-phase handshake and halfword sequencing
   drives the step pulses for the datapath and the memory strobes */
module mem_access_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     req,
  input  mem_bridge_pkg::mem_req_t req_data,
  input  logic                     need_read,
  output logic                     ack,
  output logic                     start,
  output logic                     advance,
  output logic                     capture,
  output logic                     write_phase,
  output logic                     mem_en,
  output logic                     mem_we
);

  typedef enum logic [2:0] {
    IDLE,
    READ,
    CAPTURE,
    WRITE,
    DONE
  } state_e;

  state_e                  state_q;
  state_e                  state_d;
  state_e                  hw_path;
  mem_bridge_pkg::mem_op_e op_q;
  logic [1:0]              hw_left_q;
  logic [2:0]              span;
  logic                    last_hw;
  logic                    load_now;

  // ######################################
  // halfword count of the new request

  // (low address bit + bytes + 1) / 2 gives 1, 2 or 3
  always_comb begin
    span = ({2'b00, req_data.addr[0]} + mem_bridge_pkg::width_bytes(req_data.width)
            + 3'd1) >> 1;
  end

  assign last_hw = (hw_left_q == 2'd1);

  // at start the op is not latched yet
  assign load_now = start ? (req_data.op == mem_bridge_pkg::OP_LOAD)
                          : (op_q == mem_bridge_pkg::OP_LOAD);

  // loads and partial stores read first
  assign hw_path = (load_now || need_read) ? READ : WRITE;

  // ######################################
  // next state and outputs

  always_comb begin
    state_d     = state_q;
    ack         = 1'b0;
    start       = 1'b0;
    advance     = 1'b0;
    capture     = 1'b0;
    write_phase = 1'b0;
    mem_en      = 1'b0;
    mem_we      = 1'b0;
    case (state_q)
      IDLE: begin
        if (req) begin
          start   = 1'b1;
          state_d = hw_path;
        end
      end
      READ: begin
        mem_en  = 1'b1;
        // a store merges in the cycle the read data shows up
        state_d = (op_q == mem_bridge_pkg::OP_LOAD) ? CAPTURE : WRITE;
      end
      CAPTURE: begin
        capture = 1'b1;
        advance = 1'b1;
        state_d = last_hw ? DONE : hw_path;
      end
      WRITE: begin
        mem_en      = 1'b1;
        mem_we      = 1'b1;
        write_phase = 1'b1;
        advance     = 1'b1;
        state_d     = last_hw ? DONE : hw_path;
      end
      DONE: begin
        // hold ack until the cpu lets go of req
        ack = 1'b1;
        if (!req) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      op_q      <= mem_bridge_pkg::OP_LOAD;
      hw_left_q <= 2'd0;
    end else begin
      state_q <= state_d;
      if (start) begin
        op_q      <= req_data.op;
        hw_left_q <= span[1:0];
      end else if (advance) begin
        hw_left_q <= hw_left_q - 2'd1;
      end
    end
  end

endmodule

// ==== hdl/mem_bridge_consts.svh ====
/* bus widths and memory size of the load/store bridge
   include in every file that sizes a cpu or memory signal */
`ifndef MEM_BRIDGE_CONSTS_SVH
`define MEM_BRIDGE_CONSTS_SVH

// cpu side, byte addressed
`define MB_ADDR_W     13
`define MB_DATA_W     32

// memory side, one halfword per location
`define MB_MEM_ADDR_W 12
`define MB_MEM_DATA_W 16

// halfwords in the memory
`define MB_MEM_DEPTH  4096

`endif

// ==== hdl/mem_bridge_pkg.sv ====
/* shared types of the bridge: opcode and width enums, request and memory port structs
   use the types through scoped names, mem_bridge_pkg::name */
`include "mem_bridge_consts.svh"

package mem_bridge_pkg;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } mem_op_e;

  typedef enum logic [1:0] {
    W_BYTE = 2'b00,
    W_HALF = 2'b01,
    W_WORD = 2'b10
  } mem_width_e;

  // one cpu request, held stable by the cpu until ack
  typedef struct packed {
    mem_op_e                   op;
    mem_width_e                width;
    logic                      is_signed;
    logic [`MB_ADDR_W-1:0]     addr;
    logic [`MB_DATA_W-1:0]     wdata;
  } mem_req_t;

  // bridge to memory, read is en without we
  typedef struct packed {
    logic                      en;
    logic                      we;
    logic [`MB_MEM_ADDR_W-1:0] addr;
    logic [`MB_MEM_DATA_W-1:0] wdata;
  } sram_port_t;

  // bytes moved by one access
  function automatic logic [2:0] width_bytes(input mem_width_e w);
    case (w)
      W_BYTE:  return 3'd1;
      W_HALF:  return 3'd2;
      default: return 3'd4;
    endcase
  endfunction

endpackage

// ==== hdl/mem_bridge_top.sv ====
/* load/store bridge from a 32-bit req/ack cpu port to a 16-bit synchronous memory
   connects the control FSM, address generator, load and store datapaths */
`include "mem_bridge_consts.svh"

module mem_bridge_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req,
  input  mem_bridge_pkg::mem_req_t   req_data,
  input  logic [`MB_MEM_DATA_W-1:0]  sram_rdata,
  output logic                       ack,
  output logic [`MB_DATA_W-1:0]      rdata,
  output mem_bridge_pkg::sram_port_t sram
);

  logic                      start;
  logic                      advance;
  logic                      capture;
  logic                      write_phase;
  logic                      mem_en;
  logic                      mem_we;
  logic                      need_read;
  logic [`MB_MEM_ADDR_W-1:0] hw_addr;
  logic [`MB_MEM_DATA_W-1:0] merged_wdata;

  mem_access_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .req_data    (req_data),
    .need_read   (need_read),
    .ack         (ack),
    .start       (start),
    .advance     (advance),
    .capture     (capture),
    .write_phase (write_phase),
    .mem_en      (mem_en),
    .mem_we      (mem_we)
  );

  halfword_addr_gen u_addr (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .advance   (advance),
    .byte_addr (req_data.addr),
    .hw_addr   (hw_addr)
  );

  load_assembler u_load (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .capture    (capture),
    .req_data   (req_data),
    .sram_rdata (sram_rdata),
    .rdata      (rdata)
  );

  store_merger u_store (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .advance      (advance),
    .req_data     (req_data),
    .sram_rdata   (sram_rdata),
    .need_read    (need_read),
    .merged_wdata (merged_wdata)
  );

  // memory port, write data only driven in the write cycle
  assign sram.en    = mem_en;
  assign sram.we    = mem_we;
  assign sram.addr  = hw_addr;
  assign sram.wdata = write_phase ? merged_wdata : '0;

endmodule

// ==== hdl/store_merger.sv ====
/* store data path: places store bytes in the lanes of the current halfword
   and fills uncovered lanes from the read data of a read-modify-write */
`include "mem_bridge_consts.svh"

module store_merger (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic                      advance,
  input  mem_bridge_pkg::mem_req_t  req_data,
  input  logic [`MB_MEM_DATA_W-1:0] sram_rdata,
  output logic                      need_read,
  output logic [`MB_MEM_DATA_W-1:0] merged_wdata
);

  logic [3:0][7:0] wbytes_q;
  logic [1:0]      cursor_q;
  logic [2:0]      left_q;
  logic            odd_q;
  logic [1:0]      cov;
  logic [1:0]      view_cov;
  logic [2:0]      used;
  logic [1:0]      hi_sel;

  // lanes written in a halfword, {hi, lo}
  function automatic logic [1:0] lanes_covered(input logic odd, input logic [2:0] left);
    logic lo;
    logic hi;
    lo = !odd && (left != 3'd0);
    hi = odd ? (left != 3'd0) : (left >= 3'd2);
    return {hi, lo};
  endfunction

  assign cov  = lanes_covered(odd_q, left_q);
  assign used = {2'b00, cov[1]} + {2'b00, cov[0]};

  // look ahead to the halfword the FSM dispatches next
  always_comb begin
    if (start) begin
      view_cov = lanes_covered(req_data.addr[0],
                               mem_bridge_pkg::width_bytes(req_data.width));
    end else if (advance) begin
      view_cov = lanes_covered(1'b0, left_q - used);
    end else begin
      view_cov = cov;
    end
  end

  // one lane only means read-modify-write
  assign need_read = view_cov[1] ^ view_cov[0];

  assign hi_sel = cursor_q + {1'b0, ~odd_q};

  assign merged_wdata[7:0]  = cov[0] ? wbytes_q[cursor_q] : sram_rdata[7:0];
  assign merged_wdata[15:8] = cov[1] ? wbytes_q[hi_sel] : sram_rdata[15:8];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cursor_q <= 2'd0;
      left_q   <= 3'd0;
      odd_q    <= 1'b0;
    end else if (start) begin
      cursor_q <= 2'd0;
      left_q   <= mem_bridge_pkg::width_bytes(req_data.width);
      odd_q    <= req_data.addr[0];
    end else if (advance) begin
      cursor_q <= cursor_q + used[1:0];
      left_q   <= left_q - used;
      odd_q    <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      wbytes_q <= req_data.wdata;
    end
  end

endmodule

// ==== sim/halfword_sram_model.sv ====
/* behavioral 16-bit synchronous memory for simulation
   read data appears one cycle after the read, writes land on the same edge */
`include "mem_bridge_consts.svh"

module halfword_sram_model (
  input  logic                       clk,
  input  mem_bridge_pkg::sram_port_t sram,
  output logic [`MB_MEM_DATA_W-1:0]  rdata
);

  // preloaded by the testbench through a hierarchical reference
  logic [`MB_MEM_DATA_W-1:0] mem [0:`MB_MEM_DEPTH-1];

  always @(posedge clk) begin
    if (sram.en) begin
      if (sram.we) begin
        mem[sram.addr] <= sram.wdata;
      end else begin
        rdata <= mem[sram.addr];
      end
    end
  end

endmodule

// ==== sim/mem_bridge_assertions.sv ====
/* handshake and memory port properties of the bridge
   bound to mem_bridge_top from the testbench */
module mem_bridge_assertions (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       req,
  input mem_bridge_pkg::mem_req_t   req_data,
  input logic                       ack,
  input mem_bridge_pkg::sram_port_t sram
);

  // cpu holds the request until ack
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (req && !ack) |=> (!req || $stable(req_data)))
    else $error("request data changed while waiting for ack");

  write_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
    sram.we |-> sram.en)
    else $error("memory write strobe without enable");

  ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(ack) |-> !$past(req))
    else $error("ack dropped while req was still high");

  // no memory traffic while the cpu sees ack
  quiet_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
    ack |-> !sram.en)
    else $error("memory cycle issued while ack is high");

endmodule

// ==== sim/mem_bridge_tb.sv ====
/* directed testbench of the load/store bridge against a byte-array memory reference
   build and run with the Makefile, top module mem_bridge_tb */
`include "mem_bridge_consts.svh"

module mem_bridge_tb;

  localparam int MEM_BYTES = `MB_MEM_DEPTH * 2;
  // about 80 accesses of at most 14 cycles each plus reset, with wide margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic                       clk;
  logic                       rst_n;
  logic                       req;
  mem_bridge_pkg::mem_req_t   req_data;
  logic                       ack;
  logic [`MB_DATA_W-1:0]      rdata;
  mem_bridge_pkg::sram_port_t sram;
  logic [`MB_MEM_DATA_W-1:0]  sram_rdata;
  logic [7:0]                 ref_mem [0:MEM_BYTES-1];
  int                         seed;
  int                         cycles = 0;

  mem_bridge_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .req_data   (req_data),
    .sram_rdata (sram_rdata),
    .ack        (ack),
    .rdata      (rdata),
    .sram       (sram)
  );

  halfword_sram_model u_sram (
    .clk   (clk),
    .sram  (sram),
    .rdata (sram_rdata)
  );

  bind mem_bridge_top mem_bridge_assertions u_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .sram     (sram)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1, "run stopped by the watchdog");
    end
  end

  // ########################################
  // checking and reference model

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  function automatic int byte_count(input mem_bridge_pkg::mem_width_e w);
    if (w == mem_bridge_pkg::W_BYTE) return 1;
    if (w == mem_bridge_pkg::W_HALF) return 2;
    return 4;
  endfunction

  // lower address holds the lower bits, then extend
  function automatic logic [31:0] expected_load(input mem_bridge_pkg::mem_width_e w,
                                                input logic sgn, input logic [12:0] addr);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < byte_count(w); i++) begin
      v[8*i +: 8] = ref_mem[addr + 13'(i)];
    end
    if (sgn && w == mem_bridge_pkg::W_BYTE && v[7]) v[31:8] = '1;
    if (sgn && w == mem_bridge_pkg::W_HALF && v[15]) v[31:16] = '1;
    return v;
  endfunction

  // one four-phase transaction, ack must hold while req stays high
  task automatic do_access(input mem_bridge_pkg::mem_req_t r, output logic [31:0] data);
    @(posedge clk);
    req      <= 1'b1;
    req_data <= r;
    @(negedge clk);
    while (!ack) @(negedge clk);
    data = rdata;
    @(negedge clk);
    check_value("ack", {31'd0, ack}, 32'd1);
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    while (ack) @(negedge clk);
  endtask

  task automatic store_and_track(input mem_bridge_pkg::mem_width_e w,
                                 input logic [12:0] addr, input logic [31:0] data);
    mem_bridge_pkg::mem_req_t r;
    logic [31:0]              unused_rdata;
    int                       i;
    r = '{op: mem_bridge_pkg::OP_STORE, width: w, is_signed: 1'b0, addr: addr, wdata: data};
    for (i = 0; i < byte_count(w); i++) begin
      ref_mem[addr + 13'(i)] = data[8*i +: 8];
    end
    do_access(r, unused_rdata);
  endtask

  task automatic load_and_compare(input mem_bridge_pkg::mem_width_e w, input logic sgn,
                                  input logic [12:0] addr);
    mem_bridge_pkg::mem_req_t r;
    logic [31:0]              got;
    r = '{op: mem_bridge_pkg::OP_LOAD, width: w, is_signed: sgn, addr: addr, wdata: '0};
    do_access(r, got);
    check_value($sformatf("rdata of load at %h", addr), got, expected_load(w, sgn, addr));
  endtask

  // memory model bytes against the reference, wrapping at the top
  task automatic compare_memory(input logic [12:0] lo, input int count);
    logic [12:0] a;
    logic [15:0] half;
    int          i;
    for (i = 0; i < count; i++) begin
      a    = lo + 13'(i);
      half = u_sram.mem[a[12:1]];
      check_value($sformatf("memory byte %h", a),
                  {24'd0, a[0] ? half[15:8] : half[7:0]}, {24'd0, ref_mem[a]});
    end
  endtask

  // ########################################
  // directed tests

  task automatic test_reset();
    @(negedge clk);
    check_value("ack", {31'd0, ack}, 32'd0);
    check_value("sram.en", {31'd0, sram.en}, 32'd0);
  endtask

  task automatic test_byte_lanes();
    store_and_track(mem_bridge_pkg::W_BYTE, 13'h205, 32'h0000_009c);
    compare_memory(13'h203, 4);
    store_and_track(mem_bridge_pkg::W_BYTE, 13'h204, 32'h0000_0035);
    compare_memory(13'h203, 4);
    load_and_compare(mem_bridge_pkg::W_BYTE, 1'b1, 13'h205);
    load_and_compare(mem_bridge_pkg::W_BYTE, 1'b0, 13'h205);
    load_and_compare(mem_bridge_pkg::W_BYTE, 1'b1, 13'h204);
  endtask

  task automatic test_random();
    mem_bridge_pkg::mem_width_e w;
    logic [31:0]                rnd;
    logic [31:0]                data;
    int                         k;
    for (k = 0; k < 60; k++) begin
      rnd  = $random(seed);
      data = $random(seed);
      w    = mem_bridge_pkg::mem_width_e'(2'(rnd[7:0] % 8'd3));
      if (rnd[31]) store_and_track(w, rnd[21:9], data);
      else load_and_compare(w, rnd[8], rnd[21:9]);
    end
    compare_memory(13'd0, MEM_BYTES);
  endtask

  initial begin
    int i;
    seed     = 32'h489b;
    rst_n    = 1'b0;
    req      = 1'b0;
    req_data = '0;
    for (i = 0; i < MEM_BYTES; i++) begin
      ref_mem[13'(i)] = 8'(i * 7) ^ 8'(i >> 5);
    end
    for (i = 0; i < `MB_MEM_DEPTH; i++) begin
      u_sram.mem[12'(i)] = {ref_mem[13'(2 * i + 1)], ref_mem[13'(2 * i)]};
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    // aligned word
    store_and_track(mem_bridge_pkg::W_WORD, 13'h100, 32'hdead_beef);
    load_and_compare(mem_bridge_pkg::W_WORD, 1'b0, 13'h100);
    compare_memory(13'h0fe, 8);
    test_byte_lanes();
    // odd halfword across two memory halfwords
    store_and_track(mem_bridge_pkg::W_HALF, 13'h301, 32'h0000_8a51);
    compare_memory(13'h2ff, 5);
    load_and_compare(mem_bridge_pkg::W_HALF, 1'b1, 13'h301);
    load_and_compare(mem_bridge_pkg::W_HALF, 1'b0, 13'h301);
    // odd word over three halfwords, then one wrapping past the top
    store_and_track(mem_bridge_pkg::W_WORD, 13'h403, 32'h8123_4567);
    compare_memory(13'h401, 8);
    load_and_compare(mem_bridge_pkg::W_WORD, 1'b0, 13'h403);
    store_and_track(mem_bridge_pkg::W_WORD, 13'h1fff, 32'h5a6b_7c8d);
    compare_memory(13'h1ffd, 8);
    load_and_compare(mem_bridge_pkg::W_WORD, 1'b1, 13'h1fff);
    test_random();
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/mem_bridge_pkg.sv
hdl/mem_access_ctrl.sv
hdl/halfword_addr_gen.sv
hdl/load_assembler.sv
hdl/store_merger.sv
hdl/mem_bridge_top.sv
sim/halfword_sram_model.sv
sim/mem_bridge_assertions.sv
sim/mem_bridge_tb.sv
